//--- hw/fpsu_pkg.sv
`default_nettype none

package fpsu_pkg;

  localparam int word_w = 68;
  localparam int lane_w = 33;
  localparam int fwd_sel_w = 3;

  // tag bit on top of each lane, ieee single below
  typedef struct packed {
    logic [word_w-2*lane_w-1:0] pad;
    logic [lane_w-1:0]          hi;
    logic [lane_w-1:0]          lo;
  } lanes_t;

  typedef union packed {
    logic [word_w-1:0] raw;
    lanes_t            lanes;
  } operand_u;

  // codes above op_cmp_s are illegal
  typedef enum logic [3:0] {
    op_and     = 4'd0,
    op_or      = 4'd1,
    op_xor     = 4'd2,
    op_andn    = 4'd3,
    op_perm    = 4'd4,
    op_cmpeq_p = 4'd5,
    op_cmplt_p = 4'd6,
    op_cmple_p = 4'd7,
    op_cmp_s   = 4'd8
  } fop_e;

  typedef struct packed {
    fop_e code;
    logic copy_a;
    logic swap;
    logic dup;
    logic ordered;
  } fp_op_t;

  typedef enum logic [1:0] {
    unit_logic = 2'd0,
    unit_perm  = 2'd1,
    unit_cmp   = 2'd2
  } unit_e;

  typedef enum logic [1:0] {
    rel_eq = 2'd0,
    rel_lt = 2'd1,
    rel_le = 2'd2
  } rel_e;

  typedef struct packed {
    logic       valid;
    unit_e      unit_sel;
    logic [1:0] logic_sel;
    logic       pkd;
    rel_e       rel_sel;
    logic       copy_a;
    logic       swap;
    logic       dup;
    logic       ordered;
  } exec_ctrl_t;

  typedef struct packed {
    logic unordered;
    logic equal;
    logic less;
    logic greater;
    logic a_nan;
    logic b_nan;
  } cmp_flags_t;

  typedef struct packed {
    logic invalid;
    logic denormal;
  } fp_raise_t;

  typedef struct packed {
    logic [29:0] rsvd;
    logic        den_en;
    logic        inv_en;
  } fpcsr_t;

  localparam logic [3:0] cause_invalid = 4'd1;
  localparam logic [3:0] cause_denorm  = 4'd2;

  typedef struct packed {
    logic       valid;
    logic [3:0] cause;
  } excpt_t;

endpackage

`default_nettype wire

//--- hw/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward #(
  parameter int NUM_FWD = 4
) (
  input  wire logic                                clk,
  input  wire logic                                rst,
  input  fpsu_pkg::operand_u                       direct,
  input  wire logic [fpsu_pkg::fwd_sel_w-1:0]      sel,
  input  fpsu_pkg::operand_u [NUM_FWD-1:0]         fwd_bus,
  output fpsu_pkg::operand_u                       operand
);

  fpsu_pkg::operand_u pick;

  // select 0 is the direct word, k picks bus k-1
  always_comb begin
    pick = direct;
    for (int k = 0; k < NUM_FWD; k++) begin
      if (int'(sel) == k + 1) begin
        pick = fwd_bus[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      operand <= '0;
    end else begin
      operand <= pick;
    end
  end

  sel_in_range: assert property (
    @(posedge clk) disable iff (rst) sel <= NUM_FWD
  ) else $error("forward select %0d beyond bus count", sel);

endmodule

`default_nettype wire

//--- hw/fp_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fp_op_decode (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           en,
  input  fpsu_pkg::fp_op_t    op,
  output fpsu_pkg::exec_ctrl_t ctrl
);

  fpsu_pkg::exec_ctrl_t dec;

  always_comb begin
    dec = '0;
    dec.copy_a = op.copy_a;
    dec.swap = op.swap;
    dec.dup = op.dup;
    dec.ordered = op.ordered;
    case (op.code)
      fpsu_pkg::op_and, fpsu_pkg::op_or, fpsu_pkg::op_xor, fpsu_pkg::op_andn: begin
        dec.valid = en;
        dec.unit_sel = fpsu_pkg::unit_logic;
        // low opcode bits already order and/or/xor/andn
        dec.logic_sel = op.code[1:0];
      end
      fpsu_pkg::op_perm: begin
        dec.valid = en;
        dec.unit_sel = fpsu_pkg::unit_perm;
      end
      fpsu_pkg::op_cmpeq_p: begin
        dec.valid = en;
        dec.unit_sel = fpsu_pkg::unit_cmp;
        dec.pkd = 1'b1;
        dec.rel_sel = fpsu_pkg::rel_eq;
      end
      fpsu_pkg::op_cmplt_p: begin
        dec.valid = en;
        dec.unit_sel = fpsu_pkg::unit_cmp;
        dec.pkd = 1'b1;
        dec.rel_sel = fpsu_pkg::rel_lt;
      end
      fpsu_pkg::op_cmple_p: begin
        dec.valid = en;
        dec.unit_sel = fpsu_pkg::unit_cmp;
        dec.pkd = 1'b1;
        dec.rel_sel = fpsu_pkg::rel_le;
      end
      fpsu_pkg::op_cmp_s: begin
        // scalar, flags only
        dec.valid = en;
        dec.unit_sel = fpsu_pkg::unit_cmp;
      end
      default: begin
        dec.valid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl <= '0;
    end else begin
      ctrl <= dec;
    end
  end

endmodule

`default_nettype wire

//--- hw/lane_cmp.sv
`timescale 1ns/1ps
`default_nettype none

module lane_cmp (
  input  wire logic [fpsu_pkg::lane_w-1:0] a,
  input  wire logic [fpsu_pkg::lane_w-1:0] b,
  input  wire logic                        ordered,
  output fpsu_pkg::cmp_flags_t             flags,
  output fpsu_pkg::fp_raise_t              raise
);

  logic a_nan, b_nan;
  logic a_snan, b_snan;
  logic a_den, b_den;
  logic a_zero, b_zero;
  logic unord, same, lt_raw, gt_raw;

  // tag bit 32 plays no part
  assign a_nan = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
  assign b_nan = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
  assign a_snan = a_nan && !a[22];
  assign b_snan = b_nan && !b[22];
  assign a_den = (a[30:23] == 8'h00) && (a[22:0] != 23'd0);
  assign b_den = (b[30:23] == 8'h00) && (b[22:0] != 23'd0);
  assign a_zero = (a[30:0] == 31'd0);
  assign b_zero = (b[30:0] == 31'd0);

  always_comb begin
    unord = a_nan || b_nan;
    // +0 and -0 compare equal
    same = (a[31:0] == b[31:0]) || (a_zero && b_zero);
    // less and greater come from separate magnitude compares
    case ({a[31], b[31]})
      2'b10: begin
        lt_raw = 1'b1;
        gt_raw = 1'b0;
      end
      2'b01: begin
        lt_raw = 1'b0;
        gt_raw = 1'b1;
      end
      2'b00: begin
        lt_raw = a[30:0] < b[30:0];
        gt_raw = a[30:0] > b[30:0];
      end
      default: begin
        lt_raw = a[30:0] > b[30:0];
        gt_raw = a[30:0] < b[30:0];
      end
    endcase

    flags.unordered = unord;
    flags.equal = !unord && same;
    flags.less = !unord && !same && lt_raw;
    flags.greater = !unord && !same && gt_raw;
    flags.a_nan = a_nan;
    flags.b_nan = b_nan;

    raise.invalid = a_snan || b_snan || (ordered && unord);
    raise.denormal = a_den || b_den;

    if (!$isunknown({a, b})) begin
      rel_one_hot: assert ($onehot({flags.unordered, flags.equal, flags.less, flags.greater}))
        else $error("lane compare relation is not one-hot");
    end
  end

endmodule

`default_nettype wire

//--- hw/fp_lane_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fp_lane_unit (
  input  wire logic            clk,
  input  wire logic            rst,
  input  fpsu_pkg::exec_ctrl_t ctrl,
  input  fpsu_pkg::operand_u   a,
  input  fpsu_pkg::operand_u   b,
  output fpsu_pkg::operand_u   res,
  output logic                 res_valid,
  output fpsu_pkg::cmp_flags_t flags,
  output logic                 flags_valid,
  output fpsu_pkg::fp_raise_t  raise
);

  fpsu_pkg::cmp_flags_t flags_hi, flags_lo;
  fpsu_pkg::fp_raise_t  raise_hi, raise_lo;
  fpsu_pkg::operand_u   logic_res, perm_src, perm_res, cmp_res;
  fpsu_pkg::operand_u   res_d;
  fpsu_pkg::cmp_flags_t flags_d;
  fpsu_pkg::fp_raise_t  raise_d;
  logic                 res_valid_d, flags_valid_d;

  function automatic logic rel_hold(fpsu_pkg::cmp_flags_t f, fpsu_pkg::rel_e r);
    case (r)
      fpsu_pkg::rel_eq: return f.equal;
      fpsu_pkg::rel_lt: return f.less;
      fpsu_pkg::rel_le: return f.less || f.equal;
      default: return 1'b0;
    endcase
  endfunction

  lane_cmp lane_cmp_hi (
    .a       (a.lanes.hi),
    .b       (b.lanes.hi),
    .ordered (ctrl.ordered),
    .flags   (flags_hi),
    .raise   (raise_hi)
  );

  lane_cmp lane_cmp_lo (
    .a       (a.lanes.lo),
    .b       (b.lanes.lo),
    .ordered (ctrl.ordered),
    .flags   (flags_lo),
    .raise   (raise_lo)
  );

  always_comb begin
    case (ctrl.logic_sel)
      2'd0: logic_res.raw = a.raw & b.raw;
      2'd1: logic_res.raw = a.raw | b.raw;
      2'd2: logic_res.raw = a.raw ^ b.raw;
      default: logic_res.raw = a.raw & ~b.raw;
    endcase
  end

  // swap first, dup then copies the new lo lane up
  always_comb begin
    perm_src = ctrl.copy_a ? a : b;
    perm_res = '0;
    perm_res.lanes.lo = ctrl.swap ? perm_src.lanes.hi : perm_src.lanes.lo;
    perm_res.lanes.hi = ctrl.dup ? perm_res.lanes.lo :
                        (ctrl.swap ? perm_src.lanes.lo : perm_src.lanes.hi);
  end

  always_comb begin
    cmp_res = '0;
    cmp_res.lanes.hi = {fpsu_pkg::lane_w{rel_hold(flags_hi, ctrl.rel_sel)}};
    cmp_res.lanes.lo = {fpsu_pkg::lane_w{rel_hold(flags_lo, ctrl.rel_sel)}};
  end

  always_comb begin
    res_d = '0;
    res_valid_d = 1'b0;
    flags_d = '0;
    flags_valid_d = 1'b0;
    raise_d = '0;
    if (ctrl.valid) begin
      case (ctrl.unit_sel)
        fpsu_pkg::unit_logic: begin
          res_d = logic_res;
          res_valid_d = 1'b1;
        end
        fpsu_pkg::unit_perm: begin
          res_d = perm_res;
          res_valid_d = 1'b1;
        end
        fpsu_pkg::unit_cmp: begin
          // flags always report the lo lane
          flags_d = flags_lo;
          flags_valid_d = 1'b1;
          if (ctrl.pkd) begin
            res_d = cmp_res;
            res_valid_d = 1'b1;
            raise_d = fpsu_pkg::fp_raise_t'(raise_hi | raise_lo);
          end else begin
            raise_d = raise_lo;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res <= '0;
      res_valid <= 1'b0;
      flags <= '0;
      flags_valid <= 1'b0;
      raise <= '0;
    end else begin
      res <= res_d;
      res_valid <= res_valid_d;
      flags <= flags_d;
      flags_valid <= flags_valid_d;
      raise <= raise_d;
    end
  end

  // a valid op from the decoder must name a real unit
  unit_known: assert property (
    @(posedge clk) disable iff (rst)
    ctrl.valid |-> ctrl.unit_sel inside {fpsu_pkg::unit_logic, fpsu_pkg::unit_perm,
                                         fpsu_pkg::unit_cmp}
  ) else $error("valid operation arrived with no execution unit selected");

endmodule

`default_nettype wire

//--- hw/fp_excpt.sv
`timescale 1ns/1ps
`default_nettype none

module fp_excpt (
  input  fpsu_pkg::fp_raise_t raise,
  input  wire logic           flags_valid,
  input  fpsu_pkg::fpcsr_t    fpcsr,
  output fpsu_pkg::excpt_t    excpt
);

  logic inv_hit, den_hit;

  assign inv_hit = flags_valid && raise.invalid && fpcsr.inv_en;
  assign den_hit = flags_valid && raise.denormal && fpcsr.den_en;

  // invalid wins over denormal
  always_comb begin
    excpt.valid = inv_hit || den_hit;
    if (inv_hit) begin
      excpt.cause = fpsu_pkg::cause_invalid;
    end else if (den_hit) begin
      excpt.cause = fpsu_pkg::cause_denorm;
    end else begin
      excpt.cause = 4'd0;
    end
  end

endmodule

`default_nettype wire

//--- hw/fpsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpsu_top #(
  parameter int NUM_FWD = 4
) (
  input  wire logic                           clk,
  input  wire logic                           rst,
  input  wire logic                           en,
  input  fpsu_pkg::fp_op_t                    op,
  input  fpsu_pkg::operand_u                  a,
  input  fpsu_pkg::operand_u                  b,
  input  wire logic [fpsu_pkg::fwd_sel_w-1:0] sel_a,
  input  wire logic [fpsu_pkg::fwd_sel_w-1:0] sel_b,
  input  fpsu_pkg::operand_u [NUM_FWD-1:0]    fwd_bus,
  input  fpsu_pkg::fpcsr_t                    fpcsr,
  output fpsu_pkg::operand_u                  res,
  output logic                                res_valid,
  output fpsu_pkg::cmp_flags_t                flags,
  output logic                                flags_valid,
  output fpsu_pkg::excpt_t                    excpt
);

  fpsu_pkg::operand_u   a_q, b_q;
  fpsu_pkg::exec_ctrl_t ctrl;
  fpsu_pkg::fp_raise_t  raise;

  operand_forward #(.NUM_FWD(NUM_FWD)) fwd_a_i (
    .clk     (clk),
    .rst     (rst),
    .direct  (a),
    .sel     (sel_a),
    .fwd_bus (fwd_bus),
    .operand (a_q)
  );

  operand_forward #(.NUM_FWD(NUM_FWD)) fwd_b_i (
    .clk     (clk),
    .rst     (rst),
    .direct  (b),
    .sel     (sel_b),
    .fwd_bus (fwd_bus),
    .operand (b_q)
  );

  fp_op_decode decode_i (
    .clk  (clk),
    .rst  (rst),
    .en   (en),
    .op   (op),
    .ctrl (ctrl)
  );

  fp_lane_unit lane_unit_i (
    .clk         (clk),
    .rst         (rst),
    .ctrl        (ctrl),
    .a           (a_q),
    .b           (b_q),
    .res         (res),
    .res_valid   (res_valid),
    .flags       (flags),
    .flags_valid (flags_valid),
    .raise       (raise)
  );

  fp_excpt excpt_i (
    .raise       (raise),
    .flags_valid (flags_valid),
    .fpcsr       (fpcsr),
    .excpt       (excpt)
  );

endmodule

`default_nettype wire

//--- testbench/fpsu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fpsu_checker (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           exp_push,
  input  fpsu_pkg::operand_u   exp_res,
  input  wire logic           exp_rv,
  input  fpsu_pkg::cmp_flags_t exp_flags,
  input  wire logic           exp_fv,
  input  fpsu_pkg::fp_raise_t  exp_raise,
  input  fpsu_pkg::fpcsr_t     exp_csr,
  input  fpsu_pkg::operand_u   res,
  input  wire logic           res_valid,
  input  fpsu_pkg::cmp_flags_t flags,
  input  wire logic           flags_valid,
  input  fpsu_pkg::excpt_t     excpt,
  output int                  errors,
  output int                  pending
);

  typedef struct packed {
    logic [31:0]          due;
    fpsu_pkg::operand_u   res;
    logic                 rv;
    fpsu_pkg::cmp_flags_t flags;
    logic                 fv;
    fpsu_pkg::fp_raise_t  raise;
    fpsu_pkg::fpcsr_t     csr;
  } exp_t;

  exp_t q[$];
  int edges;

  initial begin
    errors = 0;
    pending = 0;
    edges = 0;
  end

  task automatic check_val(input string name, input logic [67:0] got, input logic [67:0] want);
    if (got !== want) begin
      errors++;
      $display("MISMATCH %s got %h expected %h at edge %0d", name, got, want, edges);
    end
  endtask

  // inputs driven at edge k are seen here at k+1, results settle after edge k+2
  always @(posedge clk) begin
    edges = edges + 1;
    if (exp_push && !rst) begin
      q.push_back({32'(edges + 1), exp_res, exp_rv, exp_flags, exp_fv, exp_raise, exp_csr});
    end
    pending = q.size();
  end

  always @(negedge clk) begin
    exp_t e;
    fpsu_pkg::excpt_t x;
    logic inv, den;
    if (edges > 0) begin
      e = '0;
      if (q.size() > 0 && q[0].due == 32'(edges)) begin
        e = q.pop_front();
      end
      pending = q.size();
      // enabled raises only, invalid first
      inv = e.fv && e.raise.invalid && e.csr.inv_en;
      den = e.fv && e.raise.denormal && e.csr.den_en;
      x.valid = inv || den;
      x.cause = inv ? 4'd1 : (den ? 4'd2 : 4'd0);
      check_val("res", res.raw, e.res.raw);
      check_val("res_valid", 68'(res_valid), 68'(e.rv));
      check_val("flags", 68'(flags), 68'(e.flags));
      check_val("flags_valid", 68'(flags_valid), 68'(e.fv));
      check_val("excpt", 68'(excpt), 68'(x));
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_fpsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fpsu;

  localparam int n_rows = 40;

  typedef struct packed {
    logic                            en;
    fpsu_pkg::fp_op_t                op;
    fpsu_pkg::operand_u              a;
    fpsu_pkg::operand_u              b;
    logic [2:0]                      sel_a;
    logic [2:0]                      sel_b;
    fpsu_pkg::operand_u [3:0]        fwd;
    fpsu_pkg::fpcsr_t                csr;
    fpsu_pkg::operand_u              exp_res;
    logic                            exp_rv;
    fpsu_pkg::cmp_flags_t            exp_flags;
    logic                            exp_fv;
    fpsu_pkg::fp_raise_t             exp_raise;
  } row_t;

  logic clk, rst, en;
  fpsu_pkg::fp_op_t op;
  fpsu_pkg::operand_u a, b, res;
  logic [2:0] sel_a, sel_b;
  fpsu_pkg::operand_u [3:0] fwd_bus;
  fpsu_pkg::fpcsr_t fpcsr, csr_s1, csr_s2;
  logic res_valid, flags_valid;
  fpsu_pkg::cmp_flags_t flags;
  fpsu_pkg::excpt_t excpt;
  logic exp_push, exp_rv, exp_fv;
  fpsu_pkg::operand_u exp_res;
  fpsu_pkg::cmp_flags_t exp_flags;
  fpsu_pkg::fp_raise_t exp_raise;
  fpsu_pkg::fpcsr_t exp_csr;
  int errors, pending;
  logic [31:0] rng;
  row_t rows [n_rows];

  fpsu_top #(.NUM_FWD(4)) dut_i (
    .clk(clk), .rst(rst), .en(en), .op(op), .a(a), .b(b),
    .sel_a(sel_a), .sel_b(sel_b), .fwd_bus(fwd_bus), .fpcsr(fpcsr),
    .res(res), .res_valid(res_valid), .flags(flags),
    .flags_valid(flags_valid), .excpt(excpt)
  );

  fpsu_checker chk_i (
    .clk(clk), .rst(rst), .exp_push(exp_push), .exp_res(exp_res), .exp_rv(exp_rv),
    .exp_flags(exp_flags), .exp_fv(exp_fv), .exp_raise(exp_raise), .exp_csr(exp_csr),
    .res(res), .res_valid(res_valid), .flags(flags), .flags_valid(flags_valid),
    .excpt(excpt), .errors(errors), .pending(pending)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic fpsu_pkg::operand_u rand_word();
    logic [31:0] r0, r1, r2;
    r0 = next_rand();
    r1 = next_rand();
    r2 = next_rand();
    return fpsu_pkg::operand_u'({r2[3:0], r1, r0});
  endfunction

  function automatic fpsu_pkg::operand_u mk(logic [31:0] hi, logic [31:0] lo);
    return fpsu_pkg::operand_u'({3'b000, hi, 1'b0, lo});
  endfunction

  // {unord, eq, lt, gt, a_nan, b_nan, invalid, denormal}
  function automatic logic [7:0] lane_ref(logic [32:0] x, logic [32:0] y, logic ord);
    logic xn, yn, xs, ys, xd, yd, un, eq, lt;
    logic [31:0] kx, ky;
    xn = (x[30:23] == 8'hff) && (x[22:0] != 0);
    yn = (y[30:23] == 8'hff) && (y[22:0] != 0);
    xs = xn && !x[22];
    ys = yn && !y[22];
    xd = (x[30:23] == 8'h00) && (x[22:0] != 0);
    yd = (y[30:23] == 8'h00) && (y[22:0] != 0);
    un = xn || yn;
    eq = (x[31:0] == y[31:0]) || (x[30:0] == 0 && y[30:0] == 0);
    // monotonic integer key for sign-magnitude order
    kx = x[31] ? ~x[31:0] : (x[31:0] | 32'h8000_0000);
    ky = y[31] ? ~y[31:0] : (y[31:0] | 32'h8000_0000);
    lt = kx < ky;
    return {un, !un && eq, !un && !eq && lt, !un && !eq && !lt, xn, yn,
            xs || ys || (ord && un), xd || yd};
  endfunction

  task automatic ref_row(inout row_t r);
    fpsu_pkg::operand_u ea, eb, src;
    logic [7:0] lh, ll;
    logic hh, hl;
    ea = (r.sel_a == 0) ? r.a : r.fwd[r.sel_a - 1];
    eb = (r.sel_b == 0) ? r.b : r.fwd[r.sel_b - 1];
    r.exp_res = '0;
    r.exp_rv = 1'b0;
    r.exp_flags = '0;
    r.exp_fv = 1'b0;
    r.exp_raise = '0;
    lh = lane_ref(ea.lanes.hi, eb.lanes.hi, r.op.ordered);
    ll = lane_ref(ea.lanes.lo, eb.lanes.lo, r.op.ordered);
    if (r.en) begin
      case (r.op.code)
        fpsu_pkg::op_and: r.exp_res.raw = ea.raw & eb.raw;
        fpsu_pkg::op_or: r.exp_res.raw = ea.raw | eb.raw;
        fpsu_pkg::op_xor: r.exp_res.raw = ea.raw ^ eb.raw;
        fpsu_pkg::op_andn: r.exp_res.raw = ea.raw & ~eb.raw;
        fpsu_pkg::op_perm: begin
          src = r.op.copy_a ? ea : eb;
          r.exp_res.lanes.hi = r.op.swap ? src.lanes.lo : src.lanes.hi;
          r.exp_res.lanes.lo = r.op.swap ? src.lanes.hi : src.lanes.lo;
          if (r.op.dup) begin
            r.exp_res.lanes.hi = r.exp_res.lanes.lo;
          end
        end
        default: ;
      endcase
      r.exp_rv = r.op.code <= fpsu_pkg::op_cmple_p;
      if (r.op.code >= fpsu_pkg::op_cmpeq_p && r.op.code <= fpsu_pkg::op_cmp_s) begin
        r.exp_flags = ll[7:2];
        r.exp_fv = 1'b1;
        r.exp_raise = ll[1:0];
        if (r.op.code != fpsu_pkg::op_cmp_s) begin
          r.exp_raise = lh[1:0] | ll[1:0];
          hh = (r.op.code == fpsu_pkg::op_cmpeq_p) ? lh[6] :
               (r.op.code == fpsu_pkg::op_cmplt_p) ? lh[5] : (lh[6] | lh[5]);
          hl = (r.op.code == fpsu_pkg::op_cmpeq_p) ? ll[6] :
               (r.op.code == fpsu_pkg::op_cmplt_p) ? ll[5] : (ll[6] | ll[5]);
          r.exp_res.lanes.hi = {33{hh}};
          r.exp_res.lanes.lo = {33{hl}};
        end
      end
    end
  endtask

  task automatic set_row(input int i, input logic e, input logic [3:0] code,
                         input logic [3:0] mods, input fpsu_pkg::operand_u x,
                         input fpsu_pkg::operand_u y, input logic [1:0] csr);
    rows[i] = '0;
    rows[i].en = e;
    rows[i].op = {code, mods};
    rows[i].a = x;
    rows[i].b = y;
    rows[i].csr = fpsu_pkg::fpcsr_t'(32'(csr));
    for (int k = 0; k < 4; k++) begin
      rows[i].fwd[k] = rand_word();
    end
  endtask

  task automatic set_exp(input int i, input fpsu_pkg::operand_u r, input logic rv,
                         input logic [5:0] f, input logic fv, input logic [1:0] rs);
    rows[i].exp_res = r;
    rows[i].exp_rv = rv;
    rows[i].exp_flags = f;
    rows[i].exp_fv = fv;
    rows[i].exp_raise = rs;
  endtask

  task automatic build_table();
    logic [31:0] r;
    // mods are copy_a, swap, dup, ordered
    set_row(0, 1, 8, 4'b0000, mk(0, 32'h0), mk(0, 32'h8000_0000), 3);
    set_exp(0, '0, 0, 6'b010000, 1, 2'b00);
    set_row(1, 1, 5, 4'b0000, mk(32'h3f80_0000, 0), mk(32'h3f80_0000, 32'h8000_0000), 3);
    set_exp(1, 68'h3_ffff_ffff_ffff_ffff, 1, 6'b010000, 1, 2'b00);
    set_row(2, 1, 8, 4'b0001, mk(0, 32'h7fc0_0000), mk(0, 0), 3);
    set_exp(2, '0, 0, 6'b100010, 1, 2'b10);
    set_row(3, 1, 8, 4'b0000, mk(0, 32'h7fc0_0000), mk(0, 0), 3);
    set_exp(3, '0, 0, 6'b100010, 1, 2'b00);
    set_row(4, 1, 8, 4'b0000, mk(0, 32'h7f80_0001), mk(0, 32'h3f80_0000), 1);
    set_exp(4, '0, 0, 6'b100010, 1, 2'b10);
    set_row(5, 1, 8, 4'b0000, mk(0, 32'h7f80_0001), mk(0, 32'h3f80_0000), 0);
    set_exp(5, '0, 0, 6'b100010, 1, 2'b10);
    set_row(6, 1, 8, 4'b0000, mk(0, 32'h0000_0001), mk(0, 32'h3f80_0000), 2);
    set_exp(6, '0, 0, 6'b001000, 1, 2'b01);
    set_row(7, 1, 8, 4'b0000, mk(0, 32'h0000_0001), mk(0, 32'hff80_0001), 3);
    set_exp(7, '0, 0, 6'b100001, 1, 2'b11);
    set_row(8, 1, 4'hf, 4'b0000, rand_word(), rand_word(), 3);
    set_exp(8, '0, 0, 6'b000000, 0, 2'b00);
    set_row(9, 1, 6, 4'b0000, mk(0, 32'hbf80_0000), mk(0, 32'h3f80_0000), 3);
    set_exp(9, 68'h0_0000_0001_ffff_ffff, 1, 6'b001000, 1, 2'b00);
    set_row(10, 1, 7, 4'b0000, mk(32'h8000_0000, 32'h4000_0000), mk(0, 32'h3f80_0000), 3);
    set_exp(10, 68'h3_ffff_fffe_0000_0000, 1, 6'b000100, 1, 2'b00);
    set_row(11, 0, 0, 4'b0000, rand_word(), rand_word(), 0);
    set_exp(11, '0, 0, 6'b000000, 0, 2'b00);
    // every copy_a, swap, dup combination once
    for (int i = 12; i < 20; i++) begin
      set_row(i, 1, 4, {3'(i - 12), 1'b0}, rand_word(), rand_word(), 3);
      ref_row(rows[i]);
    end
    for (int i = 20; i < n_rows; i++) begin
      r = next_rand();
      set_row(i, (i % 9) != 8, 4'(r[7:0] % 9), r[11:8], rand_word(), rand_word(), r[13:12]);
      rows[i].sel_a = 3'(r[18:16] % 5);
      rows[i].sel_b = 3'(r[22:20] % 5);
      // sprinkle special values into compares
      if (r[25:24] == 2'b00) begin
        rows[i].a.lanes.lo = 33'h0_7fc0_0000;
        rows[i].sel_a = 0;
      end else if (r[25:24] == 2'b01) begin
        rows[i].b.lanes.hi = 33'h0_8000_0000;
        rows[i].a.lanes.hi = 33'h1_0000_0000;
        rows[i].sel_a = 0;
        rows[i].sel_b = 0;
      end
      ref_row(rows[i]);
    end
  endtask

  // fpcsr must line up with the result two cycles after issue
  always @(posedge clk) begin
    csr_s2 <= csr_s1;
    fpcsr <= csr_s2;
  end

  initial begin
    rng = 32'd55609;
    rst = 1'b1;
    en = 1'b0;
    op = '0;
    a = '0;
    b = '0;
    sel_a = '0;
    sel_b = '0;
    fwd_bus = '0;
    fpcsr = '0;
    csr_s1 = '0;
    csr_s2 = '0;
    exp_push = 1'b0;
    exp_res = '0;
    exp_rv = 1'b0;
    exp_flags = '0;
    exp_fv = 1'b0;
    exp_raise = '0;
    exp_csr = '0;
    build_table();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      en <= rows[i].en;
      op <= rows[i].op;
      a <= rows[i].a;
      b <= rows[i].b;
      sel_a <= rows[i].sel_a;
      sel_b <= rows[i].sel_b;
      fwd_bus <= rows[i].fwd;
      csr_s1 <= rows[i].csr;
      exp_push <= 1'b1;
      exp_res <= rows[i].exp_res;
      exp_rv <= rows[i].exp_rv;
      exp_flags <= rows[i].exp_flags;
      exp_fv <= rows[i].exp_fv;
      exp_raise <= rows[i].exp_raise;
      exp_csr <= rows[i].csr;
    end
    @(posedge clk);
    en <= 1'b0;
    exp_push <= 1'b0;
    repeat (2) @(posedge clk);
    while (pending != 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    $display("rows applied %0d, errors %0d", n_rows, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #((n_rows + 20) * 8 * 2);
    $display("run timed out before all results came back");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
hw/fpsu_pkg.sv
hw/operand_forward.sv
hw/fp_op_decode.sv
hw/lane_cmp.sv
hw/fp_lane_unit.sv
hw/fp_excpt.sv
hw/fpsu_top.sv
testbench/fpsu_checker.sv
testbench/tb_fpsu.sv

//--- run.sh
#!/bin/sh
# build and run the fpsu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_fpsu -o sim_fpsu \
  && out="$(./obj_dir/sim_fpsu)" \
  && echo "$out" \
  && echo "$out" | grep -q "All tests passed!" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
